// ==== logic/rvIsaPkg.sv ====
package rvIsaPkg;

   // widths of the RV32I datapath
   localparam int instW = 32;
   localparam int xlen = 32;
   localparam int regAddrW = 5;
   localparam int opClassW = 5;

   // instruction field positions
   localparam int opLsb = 2;
   localparam int rdLsb = 7;
   localparam int funct3Lsb = 12;
   localparam int rs1Lsb = 15;
   localparam int rs2Lsb = 20;
   localparam int altBit = 30;

   // opcode classes, taken from instruction bits 6..2
   localparam logic [4:0] opLoad = 5'd0;
   localparam logic [4:0] opRst = 5'd1;
   localparam logic [4:0] opImm = 5'd4;
   localparam logic [4:0] opAuipc = 5'd5;
   localparam logic [4:0] opStore = 5'd8;
   localparam logic [4:0] opReg = 5'd12;
   localparam logic [4:0] opLui = 5'd13;
   localparam logic [4:0] opBranch = 5'd24;
   localparam logic [4:0] opJalr = 5'd25;
   localparam logic [4:0] opJal = 5'd27;

   // branch conditions in funct3
   localparam logic [2:0] f3Beq = 3'd0;
   localparam logic [2:0] f3Bne = 3'd1;
   localparam logic [2:0] f3Blt = 3'd4;
   localparam logic [2:0] f3Bge = 3'd5;
   localparam logic [2:0] f3Bltu = 3'd6;
   localparam logic [2:0] f3Bgeu = 3'd7;

   // bubble loaded into the pipeline registers during reset
   // bits 6..2 decode to opRst and every other bit is zero
   localparam logic [31:0] rstBubble = 32'h0000_0004;

   // true when the class never reads the source register
   // useRs2 low asks about rs1 and high asks about rs2
   function automatic logic fwdExcluded(input logic [4:0] opClass,
                                        input logic useRs2);
      logic readsSrc;
      case (opClass)
         opLoad, opJalr, opImm: begin
            readsSrc = !useRs2;
         end
         opStore, opBranch, opReg: begin
            readsSrc = 1'b1;
         end
         // lui, auipc, jal, the bubble and illegal classes
         default: begin
            readsSrc = 1'b0;
         end
      endcase
      return !readsSrc;
   endfunction

endpackage

// ==== logic/ctrlSelPkg.sv ====
package ctrlSelPkg;

   // immediate generator formats
   localparam logic [2:0] immI = 3'd1;
   localparam logic [2:0] immS = 3'd2;
   localparam logic [2:0] immB = 3'd3;
   localparam logic [2:0] immU = 3'd4;
   localparam logic [2:0] immJ = 3'd5;
   localparam logic [2:0] immX = 3'd6;

   // ALU operations coded as {alternate bit, funct3}
   localparam logic [3:0] aluAdd = 4'd0;
   localparam logic [3:0] aluSll = 4'd1;
   localparam logic [3:0] aluSlt = 4'd2;
   localparam logic [3:0] aluSltu = 4'd3;
   localparam logic [3:0] aluXor = 4'd4;
   localparam logic [3:0] aluSrl = 4'd5;
   localparam logic [3:0] aluOr = 4'd6;
   localparam logic [3:0] aluAnd = 4'd7;
   localparam logic [3:0] aluSub = 4'd8;
   localparam logic [3:0] aluPassB = 4'd9;
   localparam logic [3:0] aluSra = 4'd13;

   // next PC source
   localparam logic [1:0] pcPlus4 = 2'd0;
   localparam logic [1:0] pcAlu = 2'd1;
   localparam logic [1:0] pcHold = 2'd2;

   // memory-mapped register select
   localparam logic [2:0] mmapCtrl = 3'd0;
   localparam logic [2:0] mmapRx = 3'd1;
   localparam logic [2:0] mmapTx = 3'd2;
   localparam logic [2:0] mmapCc = 3'd3;
   localparam logic [2:0] mmapIc = 3'd4;
   localparam logic [2:0] mmapUartRst = 3'd5;
   localparam logic [2:0] mmapNop = 3'd6;
   localparam logic [2:0] mmapNone = 3'd7;

   // UART register map
   localparam logic [31:0] uartCtrlAddr = 32'h8000_0000;
   localparam logic [31:0] uartRxAddr = 32'h8000_0004;
   localparam logic [31:0] uartTxAddr = 32'h8000_0008;
   localparam logic [31:0] uartCcAddr = 32'h8000_0010;
   localparam logic [31:0] uartIcAddr = 32'h8000_0014;
   localparam logic [31:0] uartRstAddr = 32'h8000_0018;

   // load data source and writeback source
   localparam logic [1:0] dmemRead = 2'd0;
   localparam logic [1:0] rxRead = 2'd1;
   localparam logic [1:0] uartStatRead = 2'd2;
   localparam logic [1:0] wbMem = 2'd0;
   localparam logic [1:0] wbAlu = 2'd1;
   localparam logic [1:0] wbPc4 = 2'd2;

   localparam logic [2:0] ldNone = 3'd7;
   localparam logic [1:0] storeNone = 2'd3;

   // data memory sits in regions 0001 and 0011 of the address space
   localparam logic [3:0] dmemRegionA = 4'b0001;
   localparam logic [3:0] dmemRegionB = 4'b0011;

   typedef union packed {
      logic [31:0] word;
      struct packed {
         logic [3:0] region;
         logic [27:0] offset;
      } regionView;
   } memAddr_u;

endpackage

// ==== logic/stagePipeIf.sv ====
`timescale 1ns/100ps

interface stagePipeIf
   import rvIsaPkg::*;
();

   // instruction words held in execute and writeback
   logic [instW-1:0] exInst;
   logic [instW-1:0] wbInst;
   // ALU result registered alongside wbInst
   logic [xlen-1:0] wbAluOut;
   // wbRd reads zero when the writeback instruction writes no register
   logic wbFwdValid;
   logic [regAddrW-1:0] wbRd;

   modport decode (
      output exInst,
      input wbFwdValid, wbRd
   );

   modport execute (
      input exInst, wbFwdValid, wbRd,
      output wbInst, wbAluOut
   );

   modport result (
      input wbInst, wbAluOut,
      output wbFwdValid, wbRd
   );

endinterface

// ==== logic/decodeCtrl.sv ====
`timescale 1ns/100ps

module decodeCtrl
   import rvIsaPkg::*;
   import ctrlSelPkg::*;
(
   input logic clk,
   input logic rst,
   input logic [instW-1:0] inst,
   stagePipeIf.decode pipe,
   output logic [2:0] immSel,
   output logic fwdA1,
   output logic fwdB1
);

   logic [opClassW-1:0] idClass;
   logic [regAddrW-1:0] idRs1;
   logic [regAddrW-1:0] idRs2;

   assign idClass = inst[opLsb +: opClassW];
   assign idRs1 = inst[rs1Lsb +: regAddrW];
   assign idRs2 = inst[rs2Lsb +: regAddrW];

   // immediate format of the fetched word
   always_comb begin
      case (idClass)
         opLoad, opJalr, opImm: begin
            immSel = immI;
         end
         opStore: begin
            immSel = immS;
         end
         opBranch: begin
            immSel = immB;
         end
         opJal: begin
            immSel = immJ;
         end
         opAuipc, opLui: begin
            immSel = immU;
         end
         default: begin
            immSel = immX;
         end
      endcase
   end

   // writeback result feeds the register file read in decode
   // x0 never forwards
   assign fwdA1 = pipe.wbFwdValid && (idRs1 != '0) && (idRs1 == pipe.wbRd) &&
                  !fwdExcluded(idClass, 1'b0);
   assign fwdB1 = pipe.wbFwdValid && (idRs2 != '0) && (idRs2 == pipe.wbRd) &&
                  !fwdExcluded(idClass, 1'b1);

   // decode to execute
   always_ff @(posedge clk) begin
      if (rst) begin
         pipe.exInst <= rstBubble;
      end else begin
         pipe.exInst <= inst;
      end
   end

endmodule

// ==== logic/executeCtrl.sv ====
`timescale 1ns/100ps

module executeCtrl
   import rvIsaPkg::*;
   import ctrlSelPkg::*;
(
   input logic clk,
   input logic rst,
   stagePipeIf.execute pipe,
   input logic brEq,
   input logic brLt,
   input logic [xlen-1:0] aluOut,
   output logic aSel,
   output logic bSel,
   output logic brUn,
   output logic instSel,
   output logic memRw,
   output logic dataInValid,
   output logic dataOutReady,
   output logic fwdA2,
   output logic fwdB2,
   output logic [3:0] aluSel,
   output logic [1:0] pcSel,
   output logic [1:0] storeSel,
   output logic [2:0] mmapSel
);

   logic [opClassW-1:0] exClass;
   logic [2:0] exFunct3;
   logic [regAddrW-1:0] exRs1;
   logic [regAddrW-1:0] exRs2;
   logic brTaken;

   assign exClass = pipe.exInst[opLsb +: opClassW];
   assign exFunct3 = pipe.exInst[funct3Lsb +: 3];
   assign exRs1 = pipe.exInst[rs1Lsb +: regAddrW];
   assign exRs2 = pipe.exInst[rs2Lsb +: regAddrW];

   // branch condition from the comparator flags
   always_comb begin
      case (exFunct3)
         f3Beq: brTaken = brEq;
         f3Bne: brTaken = !brEq;
         f3Blt, f3Bltu: brTaken = brLt;
         f3Bge, f3Bgeu: brTaken = !brLt;
         default: brTaken = 1'b0;
      endcase
   end

   always_comb begin
      // defaults add rs1 and the immediate
      aSel = 1'b0;
      bSel = 1'b1;
      brUn = 1'b0;
      instSel = 1'b0;
      aluSel = aluAdd;
      pcSel = pcPlus4;
      storeSel = storeNone;
      mmapSel = mmapNone;
      memRw = 1'b0;
      dataInValid = 1'b0;
      dataOutReady = 1'b0;
      case (exClass)
         opLoad: begin
            case (aluOut)
               uartCtrlAddr: mmapSel = mmapCtrl;
               uartCcAddr: mmapSel = mmapCc;
               uartIcAddr: mmapSel = mmapIc;
               uartRxAddr: begin
                  mmapSel = mmapRx;
                  dataOutReady = 1'b1;
               end
               // anything else goes to data memory
               default: memRw = 1'b1;
            endcase
         end
         opStore: begin
            storeSel = exFunct3[1:0];
            case (aluOut)
               uartRstAddr: mmapSel = mmapUartRst;
               uartTxAddr: begin
                  mmapSel = mmapTx;
                  dataInValid = 1'b1;
               end
               default: memRw = 1'b1;
            endcase
         end
         opBranch: begin
            aSel = 1'b1;
            // bltu and bgeu compare unsigned
            brUn = (exFunct3[2:1] == 2'b11);
            instSel = 1'b1;
            pcSel = brTaken ? pcAlu : pcHold;
            mmapSel = mmapNop;
         end
         opJalr, opJal: begin
            aSel = (exClass == opJal);
            instSel = 1'b1;
            pcSel = pcAlu;
            mmapSel = mmapNop;
         end
         opReg: begin
            bSel = 1'b0;
            aluSel = {pipe.exInst[altBit], exFunct3};
         end
         opImm: begin
            // bit 30 is an opcode bit only for shifts and belongs to the immediate otherwise
            if (exFunct3 == aluSll[2:0] || exFunct3 == aluSrl[2:0]) begin
               aluSel = {pipe.exInst[altBit], exFunct3};
            end else begin
               aluSel = {1'b0, exFunct3};
            end
         end
         opAuipc: aSel = 1'b1;
         opLui: aluSel = aluPassB;
         opRst: begin
            aluSel = aluPassB;
            pcSel = pcHold;
         end
         default: begin
            aluSel = aluPassB;
            instSel = 1'b1;
         end
      endcase
   end

   // writeback result into the ALU operands
   assign fwdA2 = pipe.wbFwdValid && (exRs1 != '0) && (exRs1 == pipe.wbRd) &&
                  !fwdExcluded(exClass, 1'b0);
   assign fwdB2 = pipe.wbFwdValid && (exRs2 != '0) && (exRs2 == pipe.wbRd) &&
                  !fwdExcluded(exClass, 1'b1);

   // execute to writeback
   always_ff @(posedge clk) begin
      if (rst) begin
         pipe.wbInst <= rstBubble;
         pipe.wbAluOut <= '0;
      end else begin
         pipe.wbInst <= pipe.exInst;
         pipe.wbAluOut <= aluOut;
      end
   end

endmodule

// ==== logic/resultCtrl.sv ====
`timescale 1ns/100ps

module resultCtrl
   import rvIsaPkg::*;
   import ctrlSelPkg::*;
(
   stagePipeIf.result pipe,
   output logic [2:0] ldSel,
   output logic [1:0] wbSel,
   output logic regWrEn,
   output logic [1:0] mmapDmemSel
);

   logic [opClassW-1:0] wbClass;
   memAddr_u wbAddr;
   logic inDmem;

   assign wbClass = pipe.wbInst[opLsb +: opClassW];
   assign wbAddr = pipe.wbAluOut;
   assign inDmem = (wbAddr.regionView.region == dmemRegionA) ||
                   (wbAddr.regionView.region == dmemRegionB);

   always_comb begin
      ldSel = ldNone;
      wbSel = wbMem;
      regWrEn = 1'b0;
      mmapDmemSel = dmemRead;
      case (wbClass)
         opLoad: begin
            ldSel = pipe.wbInst[funct3Lsb +: 3];
            // loads outside data memory leave the register file alone
            regWrEn = inDmem;
            case (wbAddr.word)
               uartRxAddr: mmapDmemSel = rxRead;
               uartCtrlAddr, uartCcAddr, uartIcAddr: mmapDmemSel = uartStatRead;
               default: mmapDmemSel = dmemRead;
            endcase
         end
         opJalr, opJal: begin
            wbSel = wbPc4;
            regWrEn = 1'b1;
         end
         opReg, opImm, opAuipc, opLui: begin
            wbSel = wbAlu;
            regWrEn = 1'b1;
         end
         default: begin
            regWrEn = 1'b0;
         end
      endcase
   end

   // classes that produce an rd value for the forwarding muxes
   always_comb begin
      case (wbClass)
         opLoad, opJalr, opJal, opReg, opImm, opAuipc, opLui: pipe.wbFwdValid = 1'b1;
         default: pipe.wbFwdValid = 1'b0;
      endcase
   end

   assign pipe.wbRd = pipe.wbFwdValid ? pipe.wbInst[rdLsb +: regAddrW] : '0;

endmodule

// ==== logic/pipeCtrlTop.sv ====
`timescale 1ns/100ps

module pipeCtrlTop
   import rvIsaPkg::*;
(
   input logic clk,
   input logic rst,
   input logic [instW-1:0] inst,
   input logic brEq,
   input logic brLt,
   input logic [xlen-1:0] aluOut,
   output logic [2:0] immSel,
   output logic fwdA1,
   output logic fwdB1,
   output logic aSel,
   output logic bSel,
   output logic brUn,
   output logic instSel,
   output logic memRw,
   output logic dataInValid,
   output logic dataOutReady,
   output logic fwdA2,
   output logic fwdB2,
   output logic [3:0] aluSel,
   output logic [1:0] pcSel,
   output logic [1:0] storeSel,
   output logic [2:0] mmapSel,
   output logic [2:0] ldSel,
   output logic [1:0] wbSel,
   output logic regWrEn,
   output logic [1:0] mmapDmemSel
);

   // stage state shared by the three controllers
   stagePipeIf pipe ();

   decodeCtrl decodeStage (
      .clk(clk), .rst(rst), .inst(inst), .pipe(pipe.decode),
      .immSel(immSel), .fwdA1(fwdA1), .fwdB1(fwdB1)
   );

   executeCtrl executeStage (
      .clk(clk), .rst(rst), .pipe(pipe.execute),
      .brEq(brEq), .brLt(brLt), .aluOut(aluOut),
      .aSel(aSel), .bSel(bSel), .brUn(brUn), .instSel(instSel),
      .memRw(memRw), .dataInValid(dataInValid), .dataOutReady(dataOutReady),
      .fwdA2(fwdA2), .fwdB2(fwdB2), .aluSel(aluSel), .pcSel(pcSel),
      .storeSel(storeSel), .mmapSel(mmapSel)
   );

   resultCtrl resultStage (
      .pipe(pipe.result), .ldSel(ldSel), .wbSel(wbSel),
      .regWrEn(regWrEn), .mmapDmemSel(mmapDmemSel)
   );

endmodule

// ==== bench/ctrlModel.svh ====
`ifndef CTRL_MODEL_SVH
`define CTRL_MODEL_SVH

// shadow copies of the execute and writeback stage registers
logic [31:0] exHist = rstBubble;
logic [31:0] wbHist = rstBubble;
logic [31:0] wbAluHist = '0;

// expected DUT outputs
logic [2:0] expImmSel, expMmapSel, expLdSel;
logic [3:0] expAluSel;
logic [1:0] expPcSel, expStoreSel, expWbSel, expDmemSel;
logic expFwdA1, expFwdB1, expFwdA2, expFwdB2, expASel, expBSel, expBrUn;
logic expInstSel, expMemRw, expInValid, expOutReady, expRegWrEn;

function automatic logic writesRd(input logic [4:0] cls);
   return cls inside {opLoad, opJalr, opJal, opReg, opImm, opAuipc, opLui};
endfunction

// rs2 is only read by stores, branches and register ops
function automatic logic readsSrc(input logic [4:0] cls, input logic second);
   if (second) begin
      return cls inside {opStore, opBranch, opReg};
   end
   return cls inside {opLoad, opStore, opBranch, opJalr, opReg, opImm};
endfunction

// writeback result matches a source that the word really reads
function automatic logic fwdHit(input logic [31:0] word, input logic second);
   logic [4:0] src;
   src = second ? word[24:20] : word[19:15];
   return readsSrc(word[6:2], second) && (src != 5'd0) &&
          writesRd(wbHist[6:2]) && (src == wbHist[11:7]);
endfunction

// one clock edge of the pipeline registers
task automatic shiftHistory();
   if (rst) begin
      exHist = rstBubble;
      wbHist = rstBubble;
      wbAluHist = '0;
   end else begin
      wbHist = exHist;
      wbAluHist = aluOut;
      exHist = inst;
   end
endtask

task automatic predictStages();
   logic [4:0] exCls;
   logic [4:0] wbCls;
   logic [2:0] f3;
   logic taken;
   exCls = exHist[6:2];
   wbCls = wbHist[6:2];
   f3 = exHist[14:12];
   case (inst[6:2])
      opLoad, opJalr, opImm: expImmSel = immI;
      opStore: expImmSel = immS;
      opBranch: expImmSel = immB;
      opAuipc, opLui: expImmSel = immU;
      opJal: expImmSel = immJ;
      default: expImmSel = immX;
   endcase
   expFwdA1 = fwdHit(inst, 1'b0);
   expFwdB1 = fwdHit(inst, 1'b1);
   expFwdA2 = fwdHit(exHist, 1'b0);
   expFwdB2 = fwdHit(exHist, 1'b1);

   // funct3 bit 2 picks lt over eq and bit 0 inverts the flag
   // codes 010 and 011 never branch
   taken = (f3[2:1] != 2'b01) && ((f3[2] ? brLt : brEq) ^ f3[0]);
   expASel = exCls inside {opBranch, opJal, opAuipc};
   expBSel = (exCls != opReg);
   expBrUn = (exCls == opBranch) && (f3[2:1] == 2'b11);
   expInstSel = exCls inside {opBranch, opJal, opJalr} ||
                !(exCls inside {opLoad, opStore, opReg, opImm, opAuipc, opLui, opRst});
   case (exCls)
      opReg: expAluSel = {exHist[30], f3};
      // only the shift immediates keep bit 30 as an opcode bit
      opImm: expAluSel = {exHist[30] && (f3[1:0] == 2'b01), f3};
      opLoad, opStore, opBranch, opJalr, opJal, opAuipc: expAluSel = aluAdd;
      default: expAluSel = aluPassB;
   endcase
   case (exCls)
      opBranch: expPcSel = taken ? pcAlu : pcHold;
      opJal, opJalr: expPcSel = pcAlu;
      opRst: expPcSel = pcHold;
      default: expPcSel = pcPlus4;
   endcase
   expStoreSel = (exCls == opStore) ? f3[1:0] : storeNone;

   // loads and stores outside the UART map go to data memory
   expMmapSel = (exCls inside {opBranch, opJal, opJalr}) ? mmapNop : mmapNone;
   if (exCls == opLoad) begin
      case (aluOut)
         uartCtrlAddr: expMmapSel = mmapCtrl;
         uartRxAddr: expMmapSel = mmapRx;
         uartCcAddr: expMmapSel = mmapCc;
         uartIcAddr: expMmapSel = mmapIc;
         default: ;
      endcase
   end
   if (exCls == opStore) begin
      case (aluOut)
         uartTxAddr: expMmapSel = mmapTx;
         uartRstAddr: expMmapSel = mmapUartRst;
         default: ;
      endcase
   end
   expMemRw = (exCls inside {opLoad, opStore}) && (expMmapSel == mmapNone);
   expInValid = (exCls == opStore) && (aluOut == uartTxAddr);
   expOutReady = (exCls == opLoad) && (aluOut == uartRxAddr);

   expLdSel = (wbCls == opLoad) ? wbHist[14:12] : ldNone;
   case (wbCls)
      opJal, opJalr: expWbSel = wbPc4;
      opReg, opImm, opAuipc, opLui: expWbSel = wbAlu;
      default: expWbSel = wbMem;
   endcase
   expRegWrEn = writesRd(wbCls) &&
                ((wbCls != opLoad) || (wbAluHist[31:28] inside {dmemRegionA, dmemRegionB}));
   expDmemSel = dmemRead;
   if ((wbCls == opLoad) && (wbAluHist == uartRxAddr)) begin
      expDmemSel = rxRead;
   end
   if ((wbCls == opLoad) && (wbAluHist inside {uartCtrlAddr, uartCcAddr, uartIcAddr})) begin
      expDmemSel = uartStatRead;
   end
endtask

`endif

// ==== bench/pipeCtrlTb.sv ====
`timescale 1ns/100ps

module pipeCtrlTb
   import rvIsaPkg::*;
   import ctrlSelPkg::*;
();

   localparam int clkPeriod = 8;
   localparam int rstCycles = 8;
   localparam int numCycles = 2000;

   logic clk;
   logic rst;
   logic [31:0] inst;
   logic brEq;
   logic brLt;
   logic [31:0] aluOut;
   logic [2:0] immSel, mmapSel, ldSel;
   logic [3:0] aluSel;
   logic [1:0] pcSel, storeSel, wbSel, mmapDmemSel;
   logic fwdA1, fwdB1, fwdA2, fwdB2, aSel, bSel, brUn, instSel;
   logic memRw, dataInValid, dataOutReady, regWrEn;
   integer seed = 31712;

   // classes the stimulus draws from with one illegal class at the end
   logic [4:0] classPool [11] = '{opLoad, opStore, opBranch, opJalr, opJal, opReg,
                                  opImm, opAuipc, opLui, opRst, 5'd31};
   logic [31:0] uartPool [6] = '{uartCtrlAddr, uartRxAddr, uartTxAddr,
                                 uartCcAddr, uartIcAddr, uartRstAddr};

   `include "ctrlModel.svh"

   pipeCtrlTop DUT (.*);

   initial begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   initial begin
      #(2 * (numCycles + rstCycles) * clkPeriod);
      $display("run timed out before all stimulus cycles were checked");
      $display("Test failures found");
      $fatal(1, "timeout");
   end

   // register indices limited to x0..x3 so that forwarding hits are frequent
   function automatic logic [31:0] randomInst();
      logic [31:0] word;
      word = $random(seed);
      word[6:2] = classPool[$unsigned($random(seed)) % 11];
      word[11:7] = $unsigned($random(seed)) % 4;
      word[19:15] = $unsigned($random(seed)) % 4;
      word[24:20] = $unsigned($random(seed)) % 4;
      return word;
   endfunction

   // UART registers half the time and otherwise data memory or another region
   function automatic logic [31:0] randomAddr();
      logic [31:0] word;
      word = $random(seed);
      case ($unsigned($random(seed)) % 4)
         0, 1: word = uartPool[$unsigned($random(seed)) % 6];
         2: word[31:28] = word[0] ? dmemRegionA : dmemRegionB;
         default: ;
      endcase
      return word;
   endfunction

   task automatic compareOut(input string name, input logic [31:0] got,
                             input logic [31:0] want);
      assert (got === want) else begin
         $display("error at %0t ns: %s expected %0h, got %0h", $time, name, want, got);
         $display("Test failures found");
         $fatal(1, "%s mismatch", name);
      end
   endtask

   task automatic checkOutputs();
      compareOut("immSel", immSel, expImmSel);
      compareOut("fwdA1", fwdA1, expFwdA1);
      compareOut("fwdB1", fwdB1, expFwdB1);
      compareOut("fwdA2", fwdA2, expFwdA2);
      compareOut("fwdB2", fwdB2, expFwdB2);
      compareOut("aSel", aSel, expASel);
      compareOut("bSel", bSel, expBSel);
      compareOut("brUn", brUn, expBrUn);
      compareOut("instSel", instSel, expInstSel);
      compareOut("aluSel", aluSel, expAluSel);
      compareOut("pcSel", pcSel, expPcSel);
      compareOut("storeSel", storeSel, expStoreSel);
      compareOut("mmapSel", mmapSel, expMmapSel);
      compareOut("memRw", memRw, expMemRw);
      compareOut("dataInValid", dataInValid, expInValid);
      compareOut("dataOutReady", dataOutReady, expOutReady);
      compareOut("ldSel", ldSel, expLdSel);
      compareOut("wbSel", wbSel, expWbSel);
      compareOut("regWrEn", regWrEn, expRegWrEn);
      compareOut("mmapDmemSel", mmapDmemSel, expDmemSel);
   endtask

   initial begin
      rst = 1'b1;
      inst = rstBubble;
      brEq = 1'b0;
      brLt = 1'b0;
      aluOut = '0;
      for (int cycle = 0; cycle < rstCycles + numCycles; cycle++) begin
         @(posedge clk);
         shiftHistory();
         // reset drops after its eighth edge
         if (cycle >= rstCycles - 1) begin
            rst <= 1'b0;
            inst <= randomInst();
            aluOut <= randomAddr();
            brEq <= ($random(seed) & 1) != 0;
            brLt <= ($random(seed) & 1) != 0;
         end
         @(negedge clk);
         predictStages();
         checkOutputs();
      end
      $display("All tests passed!");
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+bench
logic/rvIsaPkg.sv
logic/ctrlSelPkg.sv
logic/stagePipeIf.sv
logic/decodeCtrl.sv
logic/executeCtrl.sv
logic/resultCtrl.sv
logic/pipeCtrlTop.sv
bench/pipeCtrlTb.sv

// ==== Bender.yml ====
package:
  name: pipectrl

sources:
  - logic/rvIsaPkg.sv
  - logic/ctrlSelPkg.sv
  - logic/stagePipeIf.sv
  - logic/decodeCtrl.sv
  - logic/executeCtrl.sv
  - logic/resultCtrl.sv
  - logic/pipeCtrlTop.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/pipeCtrlTb.sv
